// File: hdl/robPkg.sv
package robPkg;

    // instruction tag handed out at issue
    typedef logic [5:0] tagT;

    // architectural register name, register 0 is hardwired to zero
    typedef logic [4:0] regNameT;

    // result and register value
    typedef logic [31:0] dataT;

    // retire and exception counters
    typedef logic [15:0] countT;

    // one reorder buffer slot, 45 bits
    typedef struct packed {
        logic    valid;
        logic    flags;
        tagT     tag;
        regNameT name;
        dataT    result;
    } robEntryT;

    // number of architectural registers
    localparam int NUM_REGS = 32;

endpackage

// File: hdl/robIf.sv
// result bus from the execution units into the ROB
interface resultIf;
    import robPkg::*;

    logic    valid;
    logic    flags;
    tagT     tag;
    regNameT name;
    dataT    result;

    // pack the bus into a ROB slot
    function automatic robEntryT asEntry();
        return {valid, flags, tag, name, result};
    endfunction

    modport producer (
        output valid, flags, tag, name, result
    );

    modport rob (
        input valid, flags, tag, name, result,
        import asEntry
    );
endinterface

// retirement bus out of the ROB head
interface commitIf;
    import robPkg::*;

    logic    valid;
    logic    flags;
    tagT     tag;
    regNameT name;
    dataT    result;

    modport rob (
        output valid, flags, tag, name, result
    );

    modport consumer (
        input valid, flags, tag, name, result
    );
endinterface

// File: hdl/rob.sv
module rob #(
    parameter int LENGTH     = 8,
    parameter int READ_WIDTH = 2
) (
    input  logic         clk,
    input  logic         rst,
    resultIf.rob         result,
    commitIf.rob         commit,
    input  logic         dequeue,
    output logic         full,
    input  robPkg::tagT  readTags [READ_WIDTH],
    output logic         readHit  [READ_WIDTH],
    output robPkg::dataT readData [READ_WIDTH]
);
    import robPkg::*;

    // slot 0 is the head (oldest), slot LENGTH-1 the tail
    robEntryT entries [LENGTH];
    logic     tailFree;

    // tail can take a result if it is empty or the queue moves this edge
    assign tailFree = dequeue || !entries[LENGTH-1].valid;
    assign full     = !tailFree;

    // shift queue, only the valid bits are cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LENGTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (dequeue) begin
                for (int i = 0; i < LENGTH - 1; i++) begin
                    entries[i] <= entries[i + 1];
                end
            end
            // an idle strobe loads an invalid slot, which later
            // shows up as a bubble on the commit bus
            if (tailFree) begin
                entries[LENGTH-1] <= result.asEntry();
            end
        end
    end

    // commit strobe, one pulse per retired entry
    always_ff @(posedge clk) begin
        if (rst) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= dequeue && entries[0].valid;
        end
    end

    // head payload captured as it leaves the queue
    always_ff @(posedge clk) begin
        if (dequeue) begin
            commit.flags  <= entries[0].flags;
            commit.tag    <= entries[0].tag;
            commit.name   <= entries[0].name;
            commit.result <= entries[0].result;
        end
    end

    // forwarding lookup
    always_comb begin
        for (int j = 0; j < READ_WIDTH; j++) begin
            readHit[j]  = 1'b0;
            readData[j] = '0;
            // scanning head to tail lets the youngest match win
            for (int i = 0; i < LENGTH; i++) begin
                if (entries[i].valid && entries[i].tag == readTags[j]) begin
                    readHit[j]  = 1'b1;
                    readData[j] = entries[i].result;
                end
            end
        end
    end

    // producer must hold off while the tail is occupied and the queue is stalled
    noStrobeWhileFull: assert property (
        @(posedge clk) disable iff (rst)
        !(result.valid && full)
    ) else $error("rob: result strobed while full");

    // retirement only happens on an edge where the queue advanced
    commitOnlyOnDequeue: assert property (
        @(posedge clk) disable iff (rst)
        commit.valid |-> $past(dequeue)
    ) else $error("rob: commit without dequeue");

endmodule

// File: hdl/archRegFile.sv
module archRegFile #(
    parameter int READ_WIDTH = 2
) (
    input  logic            clk,
    input  logic            rst,
    commitIf.consumer       commit,
    input  robPkg::regNameT readNames   [READ_WIDTH],
    input  robPkg::tagT     readTags    [READ_WIDTH],
    output robPkg::tagT     robReadTags [READ_WIDTH],
    input  logic            robHit      [READ_WIDTH],
    input  robPkg::dataT    robData     [READ_WIDTH],
    output robPkg::dataT    operandData [READ_WIDTH]
);
    import robPkg::*;

    dataT regs [NUM_REGS];
    logic writeEn;

    // excepting instructions and r0 targets leave the state alone
    assign writeEn = commit.valid && !commit.flags && commit.name != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[commit.name] <= commit.result;
        end
    end

    // tags go straight to the ROB lookup
    assign robReadTags = readTags;

    // operand select
    always_comb begin
        for (int j = 0; j < READ_WIDTH; j++) begin
            if (robHit[j]) begin
                operandData[j] = robData[j];
            end else if (writeEn && commit.name == readNames[j]) begin
                // value has left the ROB but is not in the array yet
                operandData[j] = commit.result;
            end else begin
                operandData[j] = regs[readNames[j]];
            end
        end
    end

    // r0 stays zero through every commit
    regZeroConstant: assert property (
        @(posedge clk) disable iff (rst)
        regs[0] == '0
    ) else $error("archRegFile: register 0 was written");

endmodule

// File: hdl/commitCtrl.sv
module commitCtrl (
    input  logic          clk,
    input  logic          rst,
    input  logic          cfgWrite,
    input  logic          cfgEnable,
    commitIf.consumer     commit,
    output logic          dequeue,
    output robPkg::countT retireCount,
    output robPkg::countT exceptionCount
);
    import robPkg::*;

    localparam countT COUNT_MAX = '1;

    logic commitEnable;

    // config bit, commit runs by default out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            commitEnable <= 1'b1;
        end else if (cfgWrite) begin
            commitEnable <= cfgEnable;
        end
    end

    assign dequeue = commitEnable;

    // saturating counters
    always_ff @(posedge clk) begin
        if (rst) begin
            retireCount    <= '0;
            exceptionCount <= '0;
        end else if (commit.valid) begin
            if (retireCount != COUNT_MAX) begin
                retireCount <= retireCount + 1'b1;
            end
            if (commit.flags && exceptionCount != COUNT_MAX) begin
                exceptionCount <= exceptionCount + 1'b1;
            end
        end
    end

endmodule

// File: hdl/robTop.sv
module robTop #(
    parameter int LENGTH     = 8,
    parameter int READ_WIDTH = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  logic            inFlags,
    input  robPkg::tagT     inTag,
    input  robPkg::regNameT inName,
    input  robPkg::dataT    inResult,
    input  logic            cfgWrite,
    input  logic            cfgEnable,
    input  robPkg::tagT     readTags    [READ_WIDTH],
    input  robPkg::regNameT readNames   [READ_WIDTH],
    output robPkg::dataT    operandData [READ_WIDTH],
    output logic            full,
    output logic            commitValid,
    output robPkg::tagT     commitTag,
    output robPkg::regNameT commitName,
    output logic            commitFlags,
    output robPkg::dataT    commitResult,
    output robPkg::countT   retireCount,
    output robPkg::countT   exceptionCount
);
    import robPkg::*;

    resultIf resultBus ();
    commitIf commitBus ();

    logic dequeue;
    tagT  robReadTags [READ_WIDTH];
    logic robHit      [READ_WIDTH];
    dataT robData     [READ_WIDTH];

    // execution result strobe
    assign resultBus.valid  = inValid;
    assign resultBus.flags  = inFlags;
    assign resultBus.tag    = inTag;
    assign resultBus.name   = inName;
    assign resultBus.result = inResult;

    // retirement visible at the top
    assign commitValid  = commitBus.valid;
    assign commitTag    = commitBus.tag;
    assign commitName   = commitBus.name;
    assign commitFlags  = commitBus.flags;
    assign commitResult = commitBus.result;

    rob #(
        .LENGTH     (LENGTH),
        .READ_WIDTH (READ_WIDTH)
    ) i_rob (
        .clk      (clk),
        .rst      (rst),
        .result   (resultBus.rob),
        .commit   (commitBus.rob),
        .dequeue  (dequeue),
        .full     (full),
        .readTags (robReadTags),
        .readHit  (robHit),
        .readData (robData)
    );

    archRegFile #(
        .READ_WIDTH (READ_WIDTH)
    ) i_archRegFile (
        .clk         (clk),
        .rst         (rst),
        .commit      (commitBus.consumer),
        .readNames   (readNames),
        .readTags    (readTags),
        .robReadTags (robReadTags),
        .robHit      (robHit),
        .robData     (robData),
        .operandData (operandData)
    );

    commitCtrl i_commitCtrl (
        .clk            (clk),
        .rst            (rst),
        .cfgWrite       (cfgWrite),
        .cfgEnable      (cfgEnable),
        .commit         (commitBus.consumer),
        .dequeue        (dequeue),
        .retireCount    (retireCount),
        .exceptionCount (exceptionCount)
    );

endmodule

// File: verif/robTb.sv
module robTb;
    timeunit 1ns;
    timeprecision 100ps;
    import robPkg::*;

    localparam int LENGTH     = 8;
    localparam int READ_WIDTH = 2;
    localparam int TIMEOUT    = 200;

    logic    clk;
    logic    rst;
    logic    inValid;
    logic    inFlags;
    tagT     inTag;
    regNameT inName;
    dataT    inResult;
    logic    cfgWrite;
    logic    cfgEnable;
    tagT     readTags    [READ_WIDTH];
    regNameT readNames   [READ_WIDTH];
    dataT    operandData [READ_WIDTH];
    logic    full;
    logic    commitValid;
    tagT     commitTag;
    regNameT commitName;
    logic    commitFlags;
    dataT    commitResult;
    countT   retireCount;
    countT   exceptionCount;

    // model state
    robEntryT    expQ [$];
    int          strobeCycles [$];
    dataT        shadow [NUM_REGS];
    int          cycle = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testErrors = 0;
    int          accepted = 0;
    int          flagged = 0;
    bit          checkLatency = 1'b0;
    int unsigned lcgState = 94541;

    robTop #(
        .LENGTH     (LENGTH),
        .READ_WIDTH (READ_WIDTH)
    ) i_robTop (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 8;
    endfunction

    // expected operand from the youngest queued result with that tag or else the register
    function automatic dataT refOperand(input tagT tag, input regNameT name);
        dataT value;
        value = shadow[name];
        foreach (expQ[i]) begin
            if (expQ[i].tag == tag) begin
                value = expQ[i].result;
            end
        end
        return value;
    endfunction

    // lowest tag that no queued result carries
    function automatic tagT absentTag();
        tagT pick;
        bit  used;
        pick = '0;
        for (int t = (1 << $bits(tagT)) - 1; t >= 0; t--) begin
            used = 1'b0;
            foreach (expQ[i]) begin
                if (expQ[i].tag == tagT'(t)) begin
                    used = 1'b1;
                end
            end
            if (!used) begin
                pick = tagT'(t);
            end
        end
        return pick;
    endfunction

    task automatic checkValue(input string sig, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("error at %0t: %s is %0h, expected %0h", $time, sig, got, exp);
        end
    endtask

    task automatic reportTest(input string title);
        $display("test %s: %0d errors", title, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #2;
        inValid  = 1'b0;
        cfgWrite = 1'b0;
    endtask

    task automatic sendResult(input logic flags, input tagT tag, input regNameT name,
                              input dataT value);
        int waited;
        @(posedge clk);
        #2;
        cfgWrite = 1'b0;
        waited   = 0;
        // hold off while the tail is blocked
        while (full && waited < TIMEOUT) begin
            inValid = 1'b0;
            @(posedge clk);
            #2;
            waited++;
        end
        assert (!full) else begin
            errorCount++;
            $display("timeout: full never dropped, result not sent");
        end
        if (!full) begin
            inValid  = 1'b1;
            inFlags  = flags;
            inTag    = tag;
            inName   = name;
            inResult = value;
            expQ.push_back({1'b1, flags, tag, name, value});
            // captured on the coming edge
            strobeCycles.push_back(cycle + 1);
            accepted++;
            if (flags) begin
                flagged++;
            end
        end
    endtask

    task automatic setEnable(input logic enable);
        @(posedge clk);
        #2;
        inValid   = 1'b0;
        cfgWrite  = 1'b1;
        cfgEnable = enable;
        @(posedge clk);
        #2;
        cfgWrite = 1'b0;
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (expQ.size() == 0) else begin
            errorCount++;
            $display("timeout: %0d results never retired", expQ.size());
        end
    endtask

    task automatic checkReadPair(input tagT t0, input regNameT n0, input tagT t1, input regNameT n1);
        @(posedge clk);
        #2;
        readTags[0]  = t0;
        readNames[0] = n0;
        readTags[1]  = t1;
        readNames[1] = n1;
        @(negedge clk);
        for (int j = 0; j < READ_WIDTH; j++) begin
            checkValue($sformatf("operandData[%0d]", j), operandData[j],
                       refOperand(readTags[j], readNames[j]));
        end
    endtask

    // retirement checker
    always @(negedge clk) begin
        robEntryT exp;
        int born;
        if (!rst && commitValid) begin
            assert (expQ.size() != 0) else begin
                errorCount++;
                $display("retirement at %0t with nothing outstanding", $time);
            end
            if (expQ.size() != 0) begin
                exp  = expQ.pop_front();
                born = strobeCycles.pop_front();
                checkValue("commitTag", commitTag, exp.tag);
                checkValue("commitName", commitName, exp.name);
                checkValue("commitResult", commitResult, exp.result);
                checkValue("commitFlags", commitFlags, exp.flags);
                if (checkLatency) begin
                    checkValue("commit latency", cycle - born, LENGTH);
                end
                if (!exp.flags && exp.name != '0) begin
                    shadow[exp.name] = exp.result;
                end
            end
        end
    end

    initial begin
        rst       = 1'b1;
        inValid   = 1'b0;
        inFlags   = 1'b0;
        inTag     = '0;
        inName    = '0;
        inResult  = '0;
        cfgWrite  = 1'b0;
        cfgEnable = 1'b1;
        for (int j = 0; j < READ_WIDTH; j++) begin
            readTags[j]  = '0;
            readNames[j] = '0;
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        checkValue("full", full, 0);
        checkValue("commitValid", commitValid, 0);
        checkValue("retireCount", retireCount, 0);
        checkValue("exceptionCount", exceptionCount, 0);
        for (int n = 0; n < NUM_REGS / 2; n++) begin
            checkReadPair('0, regNameT'(n), '0, regNameT'(n + NUM_REGS / 2));
        end
        reportTest("1 reset state");

        checkLatency = 1'b1;
        for (int i = 0; i < 40; i++) begin
            repeat (nextRand() % 3) idleCycle();
            sendResult(nextRand() % 5 == 0, tagT'(nextRand()), regNameT'(nextRand()),
                       dataT'(nextRand()));
        end
        idleCycle();
        waitDrained();
        checkLatency = 1'b0;
        reportTest("2 in-order retirement");

        // ROB is empty here and every read comes from the register file
        for (int n = 0; n < NUM_REGS / 2; n++) begin
            checkReadPair('0, regNameT'(n), '0, regNameT'(n + NUM_REGS / 2));
        end
        reportTest("3 register file update");

        // the last result reuses the first tag and the youngest copy has to win
        for (int i = 0; i < 4; i++) begin
            sendResult(nextRand() % 4 == 0, (i == 3) ? expQ[0].tag : tagT'(nextRand()),
                       regNameT'(nextRand()), dataT'(nextRand()));
        end
        setEnable(1'b0);
        for (int i = 0; i < 4; i++) begin
            checkReadPair(expQ[i].tag, regNameT'(nextRand()), absentTag(),
                          regNameT'(nextRand()));
        end
        reportTest("4 forwarding");

        checkValue("full", full, 0);
        sendResult(1'b0, tagT'(nextRand()), regNameT'(nextRand()), dataT'(nextRand()));
        idleCycle();
        repeat (3) begin
            @(negedge clk);
            checkValue("full", full, 1);
            checkValue("queued results", expQ.size(), 5);
        end
        setEnable(1'b1);
        waitDrained();
        @(negedge clk);
        checkValue("full", full, 0);
        reportTest("5 back-pressure");

        checkValue("retireCount", retireCount, accepted);
        checkValue("exceptionCount", exceptionCount, flagged);
        reportTest("6 counters");

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/robPkg.sv
hdl/robIf.sv
hdl/rob.sv
hdl/archRegFile.sv
hdl/commitCtrl.sv
hdl/robTop.sv
verif/robTb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run robTb, check $(LOG) for failure"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module robTb -Mdir obj_dir
	./obj_dir/VrobTb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir $(LOG)
